// File: design/peak_detect_pkg.sv
// Samples are unsigned; delay length, fall-off shift and trigger offset are fixed at elaboration
`default_nettype none

package peak_detect_pkg;

  // Width of one unsigned input sample
  localparam int SAMPLE_WIDTH = 16;

  // Number of accepted samples the output stream lags behind the input
  localparam int INPUT_DELAY = 16;

  // Holds buffer indices and occupancy counts up to INPUT_DELAY+1
  localparam int DELAY_ADDR_WIDTH = $clog2(INPUT_DELAY + 2);

  // Pulse ends below peak - (peak >> OFF_PEAK_SHIFT), so 3 gives 87.5 percent of the peak
  localparam int OFF_PEAK_SHIFT = 3;

  // Tag lands this many samples ahead of the peak (positive values only)
  localparam int PEAK_TRIGGER_OFFSET = 0;

  // Settings bus geometry
  localparam int SET_ADDR_WIDTH = 8;
  localparam int SET_DATA_WIDTH = 32;

  // Settings address of the detection threshold
  localparam logic [SET_ADDR_WIDTH-1:0] SR_THRESHOLD = 8'd5;

  // Only the low bits of the threshold register are kept
  localparam int THRESHOLD_WIDTH = 16;

  // Highest index of the circular buffer, which has INPUT_DELAY+1 entries
  localparam logic [DELAY_ADDR_WIDTH-1:0] DELAY_LAST_IDX = DELAY_ADDR_WIDTH'(INPUT_DELAY);

  // Occupancy at which the delay line starts releasing samples
  localparam logic [DELAY_ADDR_WIDTH-1:0] DELAY_FULL_COUNT =
    DELAY_ADDR_WIDTH'(INPUT_DELAY + 1);

  // Oldest peak, in samples behind the live input, that can still be tagged
  localparam logic [DELAY_ADDR_WIDTH-1:0] PEAK_AGE_LIMIT =
    DELAY_ADDR_WIDTH'(INPUT_DELAY - PEAK_TRIGGER_OFFSET);

  // Detection state machine states
  typedef enum logic [1:0] {
    S_WAIT_EXCEED  = 2'd0,
    S_TRACK_PEAK   = 2'd1,
    S_ALIGN_OUTPUT = 2'd2
  } det_state_t;

endpackage

`default_nettype wire

// File: design/setting_reg.sv
// Keeps only the low WIDTH data bits; WIDTH must not exceed the settings data width
`timescale 1ns/1ps
`default_nettype none

module setting_reg #(
  parameter logic [peak_detect_pkg::SET_ADDR_WIDTH-1:0] ADDR  = '0,
  parameter int                                         WIDTH = 32
) (
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire                                         i_set_stb,
  input  wire  [peak_detect_pkg::SET_ADDR_WIDTH-1:0]  i_set_addr,
  input  wire  [peak_detect_pkg::SET_DATA_WIDTH-1:0]  i_set_data,
  output logic [WIDTH-1:0]                            o_value
);

  // High for the one strobe cycle that targets this register
  logic hit;

  assign hit = i_set_stb && (i_set_addr == ADDR);

  // New value is visible on the cycle after the strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      o_value <= '0;
    end else if (hit) begin
      o_value <= i_set_data[WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

// File: design/sample_delay.sv
// Output stays invalid until INPUT_DELAY+1 samples are held; input ready depends on output ready
`timescale 1ns/1ps
`default_nettype none

module sample_delay (
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire  [peak_detect_pkg::SAMPLE_WIDTH-1:0]    i_tdata,
  input  wire                                         i_tvalid,
  output logic                                        o_in_ready,
  output logic [peak_detect_pkg::SAMPLE_WIDTH-1:0]    o_tdata,
  output logic                                        o_tvalid,
  input  wire                                         i_out_ready
);

  // Sample storage, one entry more than the delay so the oldest can be read
  logic [peak_detect_pkg::SAMPLE_WIDTH-1:0] mem [0:peak_detect_pkg::INPUT_DELAY];

  logic [peak_detect_pkg::DELAY_ADDR_WIDTH-1:0] wr_ptr;
  logic [peak_detect_pkg::DELAY_ADDR_WIDTH-1:0] rd_ptr;
  logic [peak_detect_pkg::DELAY_ADDR_WIDTH-1:0] count;

  logic full;
  logic wr_en;
  logic rd_en;

  // Advances a buffer index and wraps after the last entry
  function automatic logic [peak_detect_pkg::DELAY_ADDR_WIDTH-1:0] next_ptr(
    input logic [peak_detect_pkg::DELAY_ADDR_WIDTH-1:0] ptr
  );
    logic [peak_detect_pkg::DELAY_ADDR_WIDTH-1:0] nxt;
    if (ptr == peak_detect_pkg::DELAY_LAST_IDX) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full = (count == peak_detect_pkg::DELAY_FULL_COUNT);

  // A sample leaves only once INPUT_DELAY newer samples sit behind it
  assign o_tvalid = full;
  assign o_tdata  = mem[rd_ptr];

  // When full, a new sample can enter only while the oldest one leaves
  assign o_in_ready = !full || i_out_ready;

  assign wr_en = i_tvalid && o_in_ready;
  assign rd_en = o_tvalid && i_out_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_tdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Occupancy holds when a write and a read share the cycle
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/axis_reg_slice.sv
// Registered output and registered input ready; one cycle latency, full throughput
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice #(
  parameter int WIDTH = 17
) (
  input  wire               clk,
  input  wire               reset,
  input  wire  [WIDTH-1:0]  i_tdata,
  input  wire               i_tvalid,
  output logic              o_in_ready,
  output logic [WIDTH-1:0]  o_tdata,
  output logic              o_tvalid,
  input  wire               i_out_ready
);

  // Second entry catches the word accepted while the output stalls
  logic [WIDTH-1:0] skid_data;
  logic             skid_valid;

  logic in_xfer;
  logic out_free;

  // Ready comes from a flop, so the sink's ready never reaches the upstream path
  assign o_in_ready = !skid_valid;
  assign in_xfer    = i_tvalid && o_in_ready;

  // Output register can take a word when empty or when it is being read
  assign out_free = !o_tvalid || i_out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_tvalid   <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      if (skid_valid) begin
        // Drain the skid entry first to keep order
        o_tvalid   <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        o_tvalid <= in_xfer;
      end
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_valid) begin
        o_tdata <= skid_data;
      end else if (in_xfer) begin
        o_tdata <= i_tdata;
      end
    end else if (in_xfer) begin
      skid_data <= i_tdata;
    end
  end

endmodule

`default_nettype wire

// File: design/peak_detector.sv
// Tags one delayed sample per pulse; peaks older than INPUT_DELAY-PEAK_TRIGGER_OFFSET are dropped
`timescale 1ns/1ps
`default_nettype none

module peak_detector (
  input  wire                                         clk,
  input  wire                                         reset,
  input  wire                                         i_set_stb,
  input  wire  [peak_detect_pkg::SET_ADDR_WIDTH-1:0]  i_set_addr,
  input  wire  [peak_detect_pkg::SET_DATA_WIDTH-1:0]  i_set_data,
  input  wire  [peak_detect_pkg::SAMPLE_WIDTH-1:0]    i_tdata,
  input  wire                                         i_tvalid,
  output logic                                        o_tready,
  output logic [peak_detect_pkg::SAMPLE_WIDTH-1:0]    o_tdata,
  output logic                                        o_tlast,
  output logic                                        o_tvalid,
  input  wire                                         i_tready
);

  logic [peak_detect_pkg::THRESHOLD_WIDTH-1:0] threshold;

  // Delayed stream between the delay line and the output slice
  logic [peak_detect_pkg::SAMPLE_WIDTH-1:0] dly_tdata;
  logic                                     dly_tvalid;
  logic                                     dly_tready;

  // Slice word carries the trigger flag above the sample
  logic [peak_detect_pkg::SAMPLE_WIDTH:0] slice_in_tdata;
  logic [peak_detect_pkg::SAMPLE_WIDTH:0] slice_out_tdata;

  logic in_ready;
  logic in_xfer;

  peak_detect_pkg::det_state_t state;

  logic                                         trigger;
  logic [peak_detect_pkg::SAMPLE_WIDTH-1:0]     peak_val;
  logic [peak_detect_pkg::DELAY_ADDR_WIDTH-1:0] peak_offset;
  logic [peak_detect_pkg::DELAY_ADDR_WIDTH-1:0] align_cnt;

  logic                                         above_thresh;
  logic                                         new_max;
  logic                                         off_peak;
  logic [peak_detect_pkg::SAMPLE_WIDTH-1:0]     off_peak_level;
  logic [peak_detect_pkg::DELAY_ADDR_WIDTH-1:0] offset_next;

  setting_reg #(
    .ADDR  (peak_detect_pkg::SR_THRESHOLD),
    .WIDTH (peak_detect_pkg::THRESHOLD_WIDTH)
  ) u_threshold_reg (
    .clk        (clk),
    .reset      (reset),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_value    (threshold)
  );

  // Holding samples back lets the tag reach the peak after the pulse has ended
  sample_delay u_sample_delay (
    .clk         (clk),
    .reset       (reset),
    .i_tdata     (i_tdata),
    .i_tvalid    (i_tvalid),
    .o_in_ready  (in_ready),
    .o_tdata     (dly_tdata),
    .o_tvalid    (dly_tvalid),
    .i_out_ready (dly_tready)
  );

  assign slice_in_tdata = {trigger, dly_tdata};

  axis_reg_slice #(
    .WIDTH (peak_detect_pkg::SAMPLE_WIDTH + 1)
  ) u_out_slice (
    .clk         (clk),
    .reset       (reset),
    .i_tdata     (slice_in_tdata),
    .i_tvalid    (dly_tvalid),
    .o_in_ready  (dly_tready),
    .o_tdata     (slice_out_tdata),
    .o_tvalid    (o_tvalid),
    .i_out_ready (i_tready)
  );

  assign o_tlast  = slice_out_tdata[peak_detect_pkg::SAMPLE_WIDTH];
  assign o_tdata  = slice_out_tdata[peak_detect_pkg::SAMPLE_WIDTH-1:0];
  assign o_tready = in_ready;

  // Detection runs on the live input, one step per accepted sample
  assign in_xfer = i_tvalid && in_ready;

  assign above_thresh = i_tdata > threshold;

  // Strict compare keeps the first of several equal maxima
  assign new_max = i_tdata > peak_val;

  // Age of the peak once the current sample is taken into account
  assign offset_next = new_max ? '0 : peak_offset + 1'b1;

  assign off_peak_level = peak_val - (peak_val >> peak_detect_pkg::OFF_PEAK_SHIFT);
  assign off_peak       = i_tdata < off_peak_level;

  // Trigger set while accepting sample n rides beside delayed sample n-INPUT_DELAY,
  // so the tag is raised when the peak has aged exactly PEAK_AGE_LIMIT samples
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= peak_detect_pkg::S_WAIT_EXCEED;
      trigger     <= 1'b0;
      peak_offset <= '0;
      align_cnt   <= '0;
    end else if (in_xfer) begin
      // Trigger lasts for one accepted sample only
      trigger <= 1'b0;
      case (state)
        peak_detect_pkg::S_WAIT_EXCEED: begin
          peak_offset <= '0;
          align_cnt   <= '0;
          // The sample that crosses the threshold is the first candidate peak
          if (above_thresh) begin
            state <= peak_detect_pkg::S_TRACK_PEAK;
          end
        end

        peak_detect_pkg::S_TRACK_PEAK: begin
          peak_offset <= offset_next;
          if (offset_next > peak_detect_pkg::PEAK_AGE_LIMIT) begin
            // Peak has already left the delay line so the pulse is dropped untagged
            state <= peak_detect_pkg::S_WAIT_EXCEED;
          end else if (off_peak) begin
            if (offset_next == peak_detect_pkg::PEAK_AGE_LIMIT) begin
              // Peak sits at the delay output right now
              trigger <= 1'b1;
              state   <= peak_detect_pkg::S_WAIT_EXCEED;
            end else begin
              // Remaining accepted samples before the tag without counting this one
              align_cnt <= peak_detect_pkg::PEAK_AGE_LIMIT - offset_next - 1'b1;
              state     <= peak_detect_pkg::S_ALIGN_OUTPUT;
            end
          end
        end

        peak_detect_pkg::S_ALIGN_OUTPUT: begin
          if (align_cnt == '0) begin
            trigger <= 1'b1;
            state   <= peak_detect_pkg::S_WAIT_EXCEED;
          end else begin
            align_cnt <= align_cnt - 1'b1;
          end
        end

        default: begin
          state <= peak_detect_pkg::S_WAIT_EXCEED;
        end
      endcase
    end
  end

  // Peak value loads in the waiting state and then follows each new maximum
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      if (state == peak_detect_pkg::S_WAIT_EXCEED) begin
        peak_val <= above_thresh ? i_tdata : '0;
      end else if (state == peak_detect_pkg::S_TRACK_PEAK && new_max) begin
        peak_val <= i_tdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/peak_detector_asserts.sv
// Bound into peak_detector; a failure raises $error and sets error_seen, which the testbench watches
`timescale 1ns/1ps
`default_nettype none

module peak_detector_asserts (
  input wire                                          clk,
  input wire                                          reset,
  input wire [peak_detect_pkg::SAMPLE_WIDTH-1:0]      i_in_tdata,
  input wire                                          i_in_tvalid,
  input wire                                          i_in_tready,
  input wire [peak_detect_pkg::SAMPLE_WIDTH-1:0]      i_out_tdata,
  input wire                                          i_out_tlast,
  input wire                                          i_out_tvalid,
  input wire                                          i_out_tready,
  input wire                                          i_trigger,
  input wire [peak_detect_pkg::THRESHOLD_WIDTH-1:0]   i_threshold,
  input wire peak_detect_pkg::det_state_t             i_state
);

  // Sticky flag that the testbench reads through the bound instance
  logic error_seen = 1'b0;

  // First edge after reset release sees the reset values of every block
  a_reset_state: assert property (@(posedge clk) $fell(reset) |->
    !i_out_tvalid && i_in_tready && !i_trigger && i_threshold == '0 &&
    i_state == peak_detect_pkg::S_WAIT_EXCEED)
  else begin
    $error("Detector not in its reset state after reset release");
    error_seen = 1'b1;
  end

  // A stalled output word must not change or vanish
  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    i_out_tvalid && !i_out_tready |=>
    i_out_tvalid && $stable(i_out_tdata) && $stable(i_out_tlast))
  else begin
    $error("Output stream changed while the sink stalled it");
    error_seen = 1'b1;
  end

  // Same rule on the source side while the detector holds ready low
  a_in_hold: assert property (@(posedge clk) disable iff (reset)
    i_in_tvalid && !i_in_tready |=> i_in_tvalid && $stable(i_in_tdata))
  else begin
    $error("Input stream changed while the detector stalled it");
    error_seen = 1'b1;
  end

  // Words leave the slice only with data and tag read from written storage
  a_out_known: assert property (@(posedge clk) disable iff (reset)
    i_out_tvalid |-> !$isunknown({i_out_tdata, i_out_tlast}))
  else begin
    $error("Output word carries unknown data or tag");
    error_seen = 1'b1;
  end

endmodule

bind peak_detector peak_detector_asserts u_asserts (
  .clk          (clk),
  .reset        (reset),
  .i_in_tdata   (i_tdata),
  .i_in_tvalid  (i_tvalid),
  .i_in_tready  (o_tready),
  .i_out_tdata  (o_tdata),
  .i_out_tlast  (o_tlast),
  .i_out_tvalid (o_tvalid),
  .i_out_tready (i_tready),
  .i_trigger    (trigger),
  .i_threshold  (threshold),
  .i_state      (state)
);

`default_nettype wire

// File: test/tb_peak_detector.sv
// Pulses sit more than 2*INPUT_DELAY apart; the threshold is only rewritten while the input idles
`timescale 1ns/1ps
`default_nettype none

module tb_peak_detector;

  localparam int MAX_SAMPLES = 1024;

  logic                                         clk;
  logic                                         reset;
  logic                                         i_set_stb;
  logic [peak_detect_pkg::SET_ADDR_WIDTH-1:0]   i_set_addr;
  logic [peak_detect_pkg::SET_DATA_WIDTH-1:0]   i_set_data;
  logic [peak_detect_pkg::SAMPLE_WIDTH-1:0]     i_tdata;
  logic                                         i_tvalid;
  logic                                         o_tready;
  logic [peak_detect_pkg::SAMPLE_WIDTH-1:0]     o_tdata;
  logic                                         o_tlast;
  logic                                         o_tvalid;
  logic                                         i_tready;

  // Stimulus table, threshold in force per sample, and the expected tag per sample
  logic [peak_detect_pkg::SAMPLE_WIDTH-1:0] smp [0:MAX_SAMPLES-1];
  int                                       thr [0:MAX_SAMPLES-1];
  bit                                       exp_tag [0:MAX_SAMPLES-1];

  int   n_samples;
  int   rand_from;
  int   build_thr;
  int   in_cnt;
  int   out_cnt;
  bit   random_mode;
  bit   stim_ready;
  logic out_fire;

  peak_detector dut_i (
    .clk        (clk),
    .reset      (reset),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_tdata    (i_tdata),
    .i_tvalid   (i_tvalid),
    .o_tready   (o_tready),
    .o_tdata    (o_tdata),
    .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid),
    .i_tready   (i_tready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic push_sample(input int value);
    smp[n_samples] = value;
    thr[n_samples] = build_thr;
    n_samples++;
  endtask

  task automatic add_noise(input int len);
    repeat (len) push_sample(100 + $urandom_range(63));
  endtask

  // Triangle ramp of six steps where hold repeats the top value and fall adds the down ramp
  task automatic add_pulse(input int peak, input int hold, input bit fall);
    int k;
    for (k = 1; k < 6; k++) push_sample(peak * k / 6);
    repeat (hold) push_sample(peak);
    if (fall) begin
      for (k = 5; k > 0; k--) push_sample(peak * k / 6);
    end
  endtask

  task automatic add_pass();
    build_thr = 2000;
    add_noise(40);
    // Peak 1500 never crosses 2000
    add_pulse(1500, 1, 1'b1);
    add_noise(40);
    // Two equal maxima where the first one is the peak
    add_pulse(3000, 2, 1'b1);
    add_noise(40);
    build_thr = 500;
    add_pulse(1500, 1, 1'b1);
    add_noise(40);
    // Plateau lasts 17 samples past its maximum, so the pulse is dropped
    add_pulse(2500, 18, 1'b0);
    add_noise(40);
  endtask

  // Applies the detection rules to the whole table and marks where tags must land
  task automatic compute_tags();
    int i;
    int pk;
    int age_limit;
    bit tracking;
    logic [peak_detect_pkg::SAMPLE_WIDTH-1:0] pv;
    for (i = 0; i < MAX_SAMPLES; i++) exp_tag[i] = 1'b0;
    age_limit = peak_detect_pkg::INPUT_DELAY - peak_detect_pkg::PEAK_TRIGGER_OFFSET;
    tracking = 1'b0;
    i = 0;
    while (i < n_samples) begin
      if (!tracking) begin
        if (smp[i] > thr[i]) begin
          tracking = 1'b1;
          pk = i;
          pv = smp[i];
        end
      end else if (smp[i] > pv) begin
        pk = i;
        pv = smp[i];
      end else if (i - pk > age_limit) begin
        tracking = 1'b0;
      end else if (smp[i] < pv - (pv >> peak_detect_pkg::OFF_PEAK_SHIFT)) begin
        exp_tag[pk - peak_detect_pkg::PEAK_TRIGGER_OFFSET] = 1'b1;
        tracking = 1'b0;
        // No new pulse is looked for until the tag has been issued
        i = pk + age_limit;
      end
      i++;
    end
  endtask

  task automatic write_threshold(input int value);
    i_set_addr = peak_detect_pkg::SR_THRESHOLD;
    i_set_data = value;
    i_set_stb  = 1'b1;
    @(posedge clk);
    #1;
    i_set_stb = 1'b0;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      in_cnt  <= 0;
      out_cnt <= 0;
    end else begin
      if (i_tvalid && o_tready) in_cnt <= in_cnt + 1;
      if (out_fire) out_cnt <= out_cnt + 1;
    end
  end

  // Sink ready is random in the second pass
  always @(posedge clk) begin
    #1;
    i_tready = random_mode ? ($urandom_range(3) != 0) : 1'b1;
  end

  assign out_fire = o_tvalid && i_tready;

  a_out_count: assert property (@(posedge clk) disable iff (reset)
    out_fire |-> out_cnt < n_samples - peak_detect_pkg::INPUT_DELAY)
  else stop_on_error("Output transfer beyond the expected number of samples");

  a_out_data: assert property (@(posedge clk) disable iff (reset)
    out_fire |-> o_tdata == smp[out_cnt])
  else stop_on_error($sformatf("ERR o_tdata exp 0x%h got 0x%h",
    smp[$sampled(out_cnt)], $sampled(o_tdata)));

  a_out_tag: assert property (@(posedge clk) disable iff (reset)
    out_fire |-> o_tlast == exp_tag[out_cnt])
  else stop_on_error($sformatf("ERR o_tlast exp 0x%h got 0x%h at sample 0x%h",
    exp_tag[$sampled(out_cnt)], $sampled(o_tlast), $sampled(out_cnt)));

  always @(posedge clk) begin
    if (dut_i.u_asserts.error_seen) stop_on_error("Bound protocol assertion failed");
  end

  // Budget of eight clock cycles per sample plus margin for reset and drain
  initial begin
    wait (stim_ready);
    #(n_samples * 8 * 8 + 5000);
    stop_on_error("Timeout: output stream stalled");
  end

  initial begin
    int i;
    int gap;
    int cur_thr;
    void'($urandom(32'h5243));
    reset       = 1'b1;
    i_set_stb   = 1'b0;
    i_set_addr  = '0;
    i_set_data  = '0;
    i_tdata     = '0;
    i_tvalid    = 1'b0;
    i_tready    = 1'b1;
    random_mode = 1'b0;
    stim_ready  = 1'b0;
    n_samples   = 0;
    cur_thr     = 0;
    add_pass();
    rand_from = n_samples;
    add_pass();
    compute_tags();
    stim_ready = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    for (i = 0; i < n_samples; i++) begin
      random_mode = (i >= rand_from);
      if (thr[i] != cur_thr) begin
        i_tvalid = 1'b0;
        write_threshold(thr[i]);
        cur_thr = thr[i];
      end
      if (random_mode) begin
        i_tvalid = 1'b0;
        gap = $urandom_range(2);
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
      i_tdata  = smp[i];
      i_tvalid = 1'b1;
      // Valid and data hold until the detector takes the sample
      do begin
        @(posedge clk);
      end while (!o_tready);
      #1;
    end
    i_tvalid = 1'b0;
    wait (out_cnt == in_cnt - peak_detect_pkg::INPUT_DELAY);
    // Idle time in which any extra output word would trip a_out_count
    repeat (4 * peak_detect_pkg::INPUT_DELAY) @(posedge clk);
    if (in_cnt == n_samples && out_cnt == n_samples - peak_detect_pkg::INPUT_DELAY) begin
      $display("Test passed");
      $finish;
    end else begin
      stop_on_error($sformatf("ERR out_cnt exp 0x%h got 0x%h",
        n_samples - peak_detect_pkg::INPUT_DELAY, out_cnt));
    end
  end

endmodule

`default_nettype wire

// File: sources.f
design/peak_detect_pkg.sv
design/setting_reg.sv
design/sample_delay.sv
design/axis_reg_slice.sv
design/peak_detector.sv
test/peak_detector_asserts.sv
test/tb_peak_detector.sv
